// ==== Bender.yml ====
package:
  name: odd_pipe

sources:
  - files:
      - verilog/odd_pipe_pkg.sv
      - verilog/shift_rotate_unit.sv
      - verilog/branch_unit.sv
      - verilog/result_pipe.sv
      - verilog/odd_pipe_top.sv
  - target: test
    files:
      - testbench/odd_pipe_assertions.sv
      - testbench/odd_pipe_tb.sv

// ==== flist.f ====
verilog/odd_pipe_pkg.sv
verilog/shift_rotate_unit.sv
verilog/branch_unit.sv
verilog/result_pipe.sv
verilog/odd_pipe_top.sv
testbench/odd_pipe_assertions.sv
testbench/odd_pipe_tb.sv

// ==== testbench/odd_pipe_assertions.sv ====
////////////////////////////////////////////////////////////
// Odd pipe protocol assertions
// Flush source, squash at retirement and quiet outputs
// after reset, bound into the top level
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module odd_pipe_assertions (
    input logic                      clk,
    input logic                      rst,
    input odd_pipe_pkg::odd_opcode_t opcode,
    input logic                      flush,
    input logic                      rt_wr_en
);
    import odd_pipe_pkg::*;

    int fail_count = 0;

    flush_from_branch: assert property (@(posedge clk) disable iff (rst)
        flush |-> (opcode inside {op_br, op_bra, op_bi, op_brnz, op_brz, op_brhnz, op_brhz}))
        else begin
            $error("flush raised by an opcode that is not a branch");
            fail_count++;
        end

    // Two older squashed slots retire first, then the flushing slot
    squash_at_retire: assert property (@(posedge clk) disable iff (rst)
        flush |-> ##(result_latency - flush_depth + 1) !rt_wr_en [*flush_depth])
        else begin
            $error("rt_wr_en high at retirement of a flushed slot");
            fail_count++;
        end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(rst) |-> !rt_wr_en [*result_latency])
        else begin
            $error("rt_wr_en high within the pipeline depth after reset");
            fail_count++;
        end

endmodule

bind odd_pipe_top odd_pipe_assertions assertions_i (
    .clk      (clk),
    .rst      (rst),
    .opcode   (opcode),
    .flush    (flush),
    .rt_wr_en (rt_wr_en)
);

// ==== testbench/odd_pipe_stimulus.txt ====
// opcode ra rb rc imm7 imm16 pc rt_addr, then expected flush target_pc rt_data
// All fields hex, rt_addr of nop lines is replaced by a random value
1DB 800000000000000000000000000000F1 B000000000000000000000007 0 7F 0 0 01 0 0 788
1FB F0000000000000000000000000000001 7000000000000000000000000 0 04 0 0 02 0 0 10
1DF 00112233445566778899AABBCCDDEEFF 1000000000000000000000007 0 7F 0 0 03 0 0 112233445566778899AABBCCDDEEFF00
1DF 00112233445566778899AABBCCDDEEFF F000000000000000000000007 0 00 0 0 04 0 0 FF000000000000000000000000000000
1DF 00112233445566778899AABBCCDDEEFF 10000000000000000000000007 0 01 0 0 05 0 0 0
1FF 00112233445566778899AABBCCDDEEFF 7000000000000000000000000 0 25 0 0 06 0 0 5566778899AABBCCDDEEFF0000000000
1FF 00112233445566778899AABBCCDDEEFF 0 0 13 0 0 07 0 0 0
1D8 800000000000000000000000000000F1 B000000000000000000000007 0 7F 0 0 08 0 0 78C
1F8 F0000000000000000000000000000001 7000000000000000000000000 0 7C 0 0 09 0 0 1F
1DC 00112233445566778899AABBCCDDEEFF 13000000000000000000000007 0 7F 0 0 0A 0 0 33445566778899AABBCCDDEEFF001122
1FC 00112233445566778899AABBCCDDEEFF 7000000000000000000000000 0 1F 0 0 0B 0 0 FF00112233445566778899AABBCCDDEE
201 0 0 0 0 0 0 00 0 0 0
201 0 0 0 0 0 0 00 0 0 0
190 0 0 0 0 FFFC 1000 20 1 FF0 0
180 0 0 0 0 0400 1000 21 1 1000 0
1A8 2347000000000000000000000000 0 0 0 0 1000 22 1 2344 0
201 0 0 0 0 0 0 00 0 0 0
201 0 0 0 0 0 0 00 0 0 0
108 0 0 50000000000000000000000000000 0 0010 200 23 1 240 0
100 0 0 50000000000000000000000000000 0 0010 200 24 0 0 0
110 0 0 50000000000000000000000000000 0 0004 302 25 1 310 0
118 0 0 50000000000000000000000000000 0 0004 302 26 0 0 0
1FB F0000000000000000000000000000001 0 0 01 0 0 11 0 0 E0000000000000000000000000000002
1FB F0000000000000000000000000000001 0 0 02 0 0 12 0 0 C0000000000000000000000000000004
1F8 F0000000000000000000000000000001 0 0 01 0 0 13 0 0 E0000000000000000000000000000003
100 0 0 0 0 0020 400 14 1 480 0
1FF 00112233445566778899AABBCCDDEEFF 0 0 0F 0 0 15 0 0 FF000000000000000000000000000000
1DC 00112233445566778899AABBCCDDEEFF 0 0 7F 0 0 16 0 0 00112233445566778899AABBCCDDEEFF

// ==== testbench/odd_pipe_tb.sv ====
////////////////////////////////////////////////////////////
// Odd pipe testbench
// File-driven instruction stream, a retirement model with
// the flush squash, and per-cycle checks of all outputs
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module odd_pipe_tb;
    import odd_pipe_pkg::*;

    localparam int    clk_period   = 4;
    localparam int    max_lines    = 64;
    localparam int    fields       = 11;
    localparam int    drain_cycles = 10;
    localparam string stim_file    = "testbench/odd_pipe_stimulus.txt";

    logic                   clk;
    logic                   rst;
    odd_opcode_t            opcode;
    quad_t                  ra;
    quad_t                  rb;
    quad_t                  rc;
    logic [imm7_width-1:0]  imm7;
    logic [imm16_width-1:0] imm16;
    word_t                  pc;
    reg_addr_t              rt_addr;
    logic                   flush;
    word_t                  target_pc;
    logic                   rt_wr_en;
    reg_addr_t              rt_addr_out;
    quad_t                  rt_data;

    quad_t stim_mem [fields*max_lines];
    int    n_lines;
    int    errors;
    int    checks;
    logic  loaded;

    // In-flight entries, oldest at the front
    logic      model_we   [$];
    reg_addr_t model_addr [$];
    quad_t     model_data [$];

    odd_pipe_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .opcode      (opcode),
        .ra          (ra),
        .rb          (rb),
        .rc          (rc),
        .imm7        (imm7),
        .imm16       (imm16),
        .pc          (pc),
        .rt_addr     (rt_addr),
        .flush       (flush),
        .target_pc   (target_pc),
        .rt_wr_en    (rt_wr_en),
        .rt_addr_out (rt_addr_out),
        .rt_data     (rt_data)
    );

    always #(clk_period/2) clk = ~clk;

    function automatic logic writes_result(input odd_opcode_t op);
        return op inside {op_shlqbi, op_shlqbii, op_shlqby, op_shlqbyi,
                          op_rotqbi, op_rotqbii, op_rotqby, op_rotqbyi};
    endfunction

    // Unread slots keep a fill far above any opcode, which marks the end
    task automatic load_stimulus();
        for (int i = 0; i < fields*max_lines; i++) begin
            stim_mem[i] = ~quad_t'(i);
        end
        $readmemh(stim_file, stim_mem);
        n_lines = 0;
        while (n_lines < max_lines && stim_mem[fields*n_lines] <= quad_t'(11'h7ff)) begin
            n_lines++;
        end
        loaded = 1'b1;
    endtask

    task automatic issue_line(input int idx, output logic exp_flush, output word_t exp_target,
                              output logic exp_we, output reg_addr_t exp_addr,
                              output quad_t exp_data);
        quad_t       f [fields];
        odd_opcode_t op;
        for (int k = 0; k < fields; k++) begin
            f[k] = (idx < n_lines) ? stim_mem[idx*fields + k] : '0;
        end
        if (idx >= n_lines) begin
            f[0] = quad_t'(op_nop);
        end
        op = odd_opcode_t'(f[0][opcode_width-1:0]);
        exp_addr = reg_addr_t'(f[7]);
        if (op == op_nop && idx < n_lines) begin
            exp_addr = reg_addr_t'($urandom);
        end
        exp_flush  = f[8][0];
        exp_target = f[9][word_width-1:0];
        exp_we     = writes_result(op);
        exp_data   = f[10];
        opcode  <= op;
        ra      <= f[1];
        rb      <= f[2];
        rc      <= f[3];
        imm7    <= f[4][imm7_width-1:0];
        imm16   <= f[5][imm16_width-1:0];
        pc      <= f[6][word_width-1:0];
        rt_addr <= exp_addr;
    endtask

    task automatic check_cycle(input logic exp_flush, input word_t exp_target,
                               input logic exp_we, input reg_addr_t exp_addr,
                               input quad_t exp_data);
        checks++;
        assert (flush === exp_flush) else begin
            $display("FAIL flush: got %h, expected %h", flush, exp_flush);
            errors++;
        end
        if (exp_flush) begin
            assert (target_pc === exp_target) else begin
                $display("FAIL target_pc: got %h, expected %h", target_pc, exp_target);
                errors++;
            end
        end
        assert (rt_wr_en === model_we[0]) else begin
            $display("FAIL rt_wr_en: got %h, expected %h", rt_wr_en, model_we[0]);
            errors++;
        end
        assert (rt_addr_out === model_addr[0]) else begin
            $display("FAIL rt_addr_out: got %h, expected %h", rt_addr_out, model_addr[0]);
            errors++;
        end
        assert (rt_data === model_data[0]) else begin
            $display("FAIL rt_data: got %h, expected %h", rt_data, model_data[0]);
            errors++;
        end
        void'(model_we.pop_front());
        void'(model_addr.pop_front());
        void'(model_data.pop_front());
        model_we.push_back(exp_we);
        model_addr.push_back(exp_addr);
        model_data.push_back(exp_data);
        // Taken branch clears itself and the two entries behind it
        if (exp_flush) begin
            for (int i = model_we.size() - flush_depth; i < model_we.size(); i++) begin
                model_we[i]   = 1'b0;
                model_addr[i] = '0;
                model_data[i] = '0;
            end
        end
    endtask

    initial begin
        logic      exp_flush;
        word_t     exp_target;
        logic      exp_we;
        reg_addr_t exp_addr;
        quad_t     exp_data;
        clk     = 1'b0;
        rst     = 1'b1;
        opcode  = op_nop;
        ra      = '0;
        rb      = '0;
        rc      = '0;
        imm7    = '0;
        imm16   = '0;
        pc      = '0;
        rt_addr = '0;
        errors  = 0;
        checks  = 0;
        loaded  = 1'b0;
        void'($urandom(32'h85d32c14));
        // Pipeline is all zeros coming out of reset
        for (int i = 0; i < result_latency; i++) begin
            model_we.push_back(1'b0);
            model_addr.push_back('0);
            model_data.push_back('0);
        end
        load_stimulus();
        assert (n_lines > 0) else begin
            $display("No instructions could be read from %s", stim_file);
            errors++;
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < n_lines + drain_cycles; i++) begin
            issue_line(i, exp_flush, exp_target, exp_we, exp_addr, exp_data);
            @(negedge clk);
            check_cycle(exp_flush, exp_target, exp_we, exp_addr, exp_data);
            @(posedge clk);
        end
        $display("Cycles checked: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, dut_i.assertions_i.fail_count);
        if (errors == 0 && dut_i.assertions_i.fail_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (loaded === 1'b1);
        #((n_lines + 20) * clk_period);
        $display("Timeout: the run did not finish within %0d clock cycles", n_lines + 20);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== verilog/branch_unit.sv ====
////////////////////////////////////////////////////////////
// Branch resolution unit
// Decides taken branches and computes their target,
// raising flush in the same cycle
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module branch_unit (
    input  odd_pipe_pkg::odd_opcode_t            opcode,
    input  odd_pipe_pkg::quad_t                  ra,
    input  odd_pipe_pkg::quad_t                  rc,
    input  logic [odd_pipe_pkg::imm16_width-1:0] imm16,
    input  odd_pipe_pkg::word_t                  pc,
    output logic                                 flush,
    output odd_pipe_pkg::word_t                  target_pc
);
    import odd_pipe_pkg::*;

    word_t offset;
    word_t rel_target;
    word_t align_mask;
    word_t pref_ra;
    word_t pref_rc;

    // Sign-extended word offset
    assign offset = {{(word_width-imm16_width-inst_align_bits){imm16[imm16_width-1]}},
                     imm16, {inst_align_bits{1'b0}}};
    assign rel_target = pc + offset;
    assign align_mask = ~word_t'(inst_align - 1);
    assign pref_ra    = ra[quad_width-1 -: word_width];
    assign pref_rc    = rc[quad_width-1 -: word_width];

    always_comb begin
        flush     = 1'b0;
        target_pc = pc + word_t'(inst_align);
        case (opcode)
            op_br: begin
                flush     = 1'b1;
                target_pc = rel_target;
            end
            op_bra: begin
                flush     = 1'b1;
                target_pc = offset;
            end
            op_bi: begin
                flush     = 1'b1;
                target_pc = pref_ra & align_mask;
            end
            op_brnz: flush = (pref_rc != '0);
            op_brz: flush = (pref_rc == '0);
            op_brhnz: flush = (pref_rc[word_width/2-1:0] != '0);
            op_brhz: flush = (pref_rc[word_width/2-1:0] == '0);
            default: ;
        endcase
        // Conditional forms only reach here taken
        if (flush && !(opcode inside {op_br, op_bra, op_bi})) begin
            target_pc = rel_target & align_mask;
        end
    end

endmodule

// ==== verilog/odd_pipe_pkg.sv ====
////////////////////////////////////////////////////////////
// Odd pipe shared definitions
// Widths, immediate sizes, pipeline depths, count limits
// and the opcode encoding of the odd execution pipe
////////////////////////////////////////////////////////////

package odd_pipe_pkg;

    // Datapath widths
    localparam int quad_width     = 128;
    localparam int word_width     = 32;
    localparam int reg_addr_width = 7;
    localparam int opcode_width   = 11;

    // Immediate fields
    localparam int imm7_width  = 7;
    localparam int imm16_width = 16;

    // Result pipeline
    localparam int result_latency = 8;
    localparam int flush_depth    = 3;

    // Byte shift counts at or above this clear the result
    localparam int max_byte_shift = 16;

    // Instruction alignment in bytes, also the fall-through step
    localparam int inst_align      = 4;
    localparam int inst_align_bits = $clog2(inst_align);

    typedef logic [quad_width-1:0]     quad_t;
    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    typedef enum logic [opcode_width-1:0] {
        op_nop     = 11'h201,
        // Quadword shift left
        op_shlqbi  = 11'h1DB,
        op_shlqbii = 11'h1FB,
        op_shlqby  = 11'h1DF,
        op_shlqbyi = 11'h1FF,
        // Quadword rotate left
        op_rotqbi  = 11'h1D8,
        op_rotqbii = 11'h1F8,
        op_rotqby  = 11'h1DC,
        op_rotqbyi = 11'h1FC,
        // Unconditional branches
        op_br      = 11'h190,
        op_bra     = 11'h180,
        op_bi      = 11'h1A8,
        // Conditional branches on word or halfword
        op_brnz    = 11'h108,
        op_brz     = 11'h100,
        op_brhnz   = 11'h118,
        op_brhz    = 11'h110
    } odd_opcode_t;

endpackage

// ==== verilog/odd_pipe_top.sv ====
////////////////////////////////////////////////////////////
// Odd execution pipe top level
// Shift/rotate and branch units feeding the result pipeline
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module odd_pipe_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  odd_pipe_pkg::odd_opcode_t            opcode,
    input  odd_pipe_pkg::quad_t                  ra,
    input  odd_pipe_pkg::quad_t                  rb,
    input  odd_pipe_pkg::quad_t                  rc,
    input  logic [odd_pipe_pkg::imm7_width-1:0]  imm7,
    input  logic [odd_pipe_pkg::imm16_width-1:0] imm16,
    input  odd_pipe_pkg::word_t                  pc,
    input  odd_pipe_pkg::reg_addr_t              rt_addr,
    output logic                                 flush,
    output odd_pipe_pkg::word_t                  target_pc,
    output logic                                 rt_wr_en,
    output odd_pipe_pkg::reg_addr_t              rt_addr_out,
    output odd_pipe_pkg::quad_t                  rt_data
);
    import odd_pipe_pkg::*;

    logic  sr_wr_en;
    quad_t sr_result;

    shift_rotate_unit shift_rotate_i (
        .opcode    (opcode),
        .ra        (ra),
        .rb        (rb),
        .imm7      (imm7),
        .sr_wr_en  (sr_wr_en),
        .sr_result (sr_result)
    );

    branch_unit branch_i (
        .opcode    (opcode),
        .ra        (ra),
        .rc        (rc),
        .imm16     (imm16),
        .pc        (pc),
        .flush     (flush),
        .target_pc (target_pc)
    );

    result_pipe result_pipe_i (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .wr_en       (sr_wr_en),
        .addr        (rt_addr),
        .data        (sr_result),
        .rt_wr_en    (rt_wr_en),
        .rt_addr_out (rt_addr_out),
        .rt_data     (rt_data)
    );

endmodule

// ==== verilog/result_pipe.sv ====
////////////////////////////////////////////////////////////
// Result retirement pipeline
// Fixed-depth delay of write enable, address and data;
// a flush squashes the youngest entries
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module result_pipe (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      flush,
    input  logic                      wr_en,
    input  odd_pipe_pkg::reg_addr_t   addr,
    input  odd_pipe_pkg::quad_t       data,
    output logic                      rt_wr_en,
    output odd_pipe_pkg::reg_addr_t   rt_addr_out,
    output odd_pipe_pkg::quad_t       rt_data
);
    import odd_pipe_pkg::*;

    logic      we_q   [result_latency];
    reg_addr_t addr_q [result_latency];
    quad_t     data_q [result_latency];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < result_latency; i++) begin
                we_q[i]   <= 1'b0;
                addr_q[i] <= '0;
                data_q[i] <= '0;
            end
        end else begin
            // New entry, dropped when its own cycle flushes
            we_q[0]   <= flush ? 1'b0 : wr_en;
            addr_q[0] <= flush ? '0 : addr;
            data_q[0] <= flush ? '0 : data;
            for (int i = 1; i < result_latency; i++) begin
                if (flush && (i < flush_depth)) begin
                    we_q[i]   <= 1'b0;
                    addr_q[i] <= '0;
                    data_q[i] <= '0;
                end else begin
                    we_q[i]   <= we_q[i-1];
                    addr_q[i] <= addr_q[i-1];
                    data_q[i] <= data_q[i-1];
                end
            end
        end
    end

    assign rt_wr_en    = we_q[result_latency-1];
    assign rt_addr_out = addr_q[result_latency-1];
    assign rt_data     = data_q[result_latency-1];

endmodule

// ==== verilog/shift_rotate_unit.sv ====
////////////////////////////////////////////////////////////
// Quadword shift and rotate unit
// Left shifts and rotates by bits or bytes, with register
// or immediate count, plus the result write enable
////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module shift_rotate_unit (
    input  odd_pipe_pkg::odd_opcode_t           opcode,
    input  odd_pipe_pkg::quad_t                 ra,
    input  odd_pipe_pkg::quad_t                 rb,
    input  logic [odd_pipe_pkg::imm7_width-1:0] imm7,
    output logic                                sr_wr_en,
    output odd_pipe_pkg::quad_t                 sr_result
);
    import odd_pipe_pkg::*;

    logic                    use_imm;
    logic                    is_rot;
    logic                    is_byte;
    word_t                   pref_rb;
    logic [imm7_width-1:0]   count;
    logic [7:0]              shamt;
    logic [2*quad_width-1:0] dbl;
    quad_t                   shl_result;
    quad_t                   rot_result;
    logic                    byte_oor;

    always_comb begin
        sr_wr_en = 1'b1;
        use_imm  = 1'b0;
        is_rot   = 1'b0;
        is_byte  = 1'b0;
        case (opcode)
            op_shlqbi: ;
            op_shlqbii: use_imm = 1'b1;
            op_shlqby: is_byte = 1'b1;
            op_shlqbyi: begin
                is_byte = 1'b1;
                use_imm = 1'b1;
            end
            op_rotqbi: is_rot = 1'b1;
            op_rotqbii: begin
                is_rot  = 1'b1;
                use_imm = 1'b1;
            end
            op_rotqby: begin
                is_rot  = 1'b1;
                is_byte = 1'b1;
            end
            op_rotqbyi: begin
                is_rot  = 1'b1;
                is_byte = 1'b1;
                use_imm = 1'b1;
            end
            default: sr_wr_en = 1'b0;
        endcase
    end

    // Count sits in the low bits of the preferred word
    assign pref_rb = rb[quad_width-1 -: word_width];
    assign count   = use_imm ? imm7 : pref_rb[imm7_width-1:0];

    always_comb begin
        if (!is_byte) begin
            shamt = {5'b0, count[2:0]};
        end else if (is_rot) begin
            shamt = {1'b0, count[3:0], 3'b000};
        end else begin
            shamt = {count[4:0], 3'b000};
        end
    end

    // Rotate via doubled operand, top half wraps MSBs to LSBs
    assign dbl        = {ra, ra} << shamt;
    assign rot_result = dbl[2*quad_width-1 -: quad_width];
    assign shl_result = ra << shamt;
    assign byte_oor   = is_byte && (count[4:0] >= max_byte_shift);

    always_comb begin
        if (!sr_wr_en) begin
            sr_result = '0;
        end else if (is_rot) begin
            sr_result = rot_result;
        end else if (byte_oor) begin
            sr_result = '0;
        end else begin
            sr_result = shl_result;
        end
    end

endmodule
